//--- bench/csr_unit_testdata.txt
# op csr wdata wmask pc excp_valid ecode badv hw_int | exp_rdata exp_flush exp_target mode
# all hex; mode 0 plain, 1 excp_flush pulse, 2 ertn_flush pulse, 3 under flush, 4 await interrupt
2 030 11111111 ffffffff 1c000000 0 00 00000000 000 00000000 1 1c000004 0
2 031 22222222 ffffffff 1c000004 0 00 00000000 000 00000000 1 1c000008 0
2 032 33333333 ffffffff 1c000008 0 00 00000000 000 00000000 1 1c00000c 0
2 033 44444444 ffffffff 1c00000c 0 00 00000000 000 00000000 1 1c000010 0
2 040 5a5a0001 ffffffff 1c000010 0 00 00000000 000 00000000 1 1c000014 0
2 006 1c000100 ffffffff 1c000014 0 00 00000000 000 00000000 1 1c000018 0
2 00c 1c00803f ffffffff 1c000018 0 00 00000000 000 00000000 1 1c00001c 0
1 030 00000000 00000000 1c00001c 0 00 00000000 000 11111111 0 1c000020 0
1 031 00000000 00000000 1c000020 0 00 00000000 000 22222222 0 1c000024 0
1 032 00000000 00000000 1c000024 0 00 00000000 000 33333333 0 1c000028 0
1 033 00000000 00000000 1c000028 0 00 00000000 000 44444444 0 1c00002c 0
1 040 00000000 00000000 1c00002c 0 00 00000000 000 5a5a0001 0 1c000030 0
1 006 00000000 00000000 1c000030 0 00 00000000 000 1c000100 0 1c000034 0
1 00c 00000000 00000000 1c000034 0 00 00000000 000 1c008000 0 1c000038 0
2 030 aaaaaaaa ffffffff 1c000038 0 00 00000000 000 11111111 1 1c00003c 0
3 031 ffff0000 00ffff00 1c00003c 0 00 00000000 000 22222222 1 1c000040 0
1 031 00000000 00000000 1c000040 0 00 00000000 000 22ff0022 0 1c000044 0
2 004 ffffffff ffffffff 1c000044 0 00 00000000 000 00000000 1 1c000048 0
1 004 00000000 00000000 1c000048 0 00 00000000 000 00001bff 0 1c00004c 0
2 000 00000007 ffffffff 1c00004c 0 00 00000000 000 00000008 1 1c000050 0
1 000 00000000 00000000 1c000050 0 00 00000000 000 0000000f 0 1c000054 0
4 000 00000000 00000000 1c000200 1 0b 00000000 000 0000000f 1 1c008000 1
1 006 00000000 00000000 1c008000 0 00 00000000 000 1c000200 0 1c008004 0
1 005 00000000 00000000 1c008004 0 00 00000000 000 000b0000 0 1c008008 0
1 001 00000000 00000000 1c008008 0 00 00000000 000 00000007 0 1c00800c 0
1 000 00000000 00000000 1c00800c 0 00 00000000 000 00000008 0 1c008010 0
5 000 00000000 00000000 1c008010 0 00 00000000 000 00000008 1 1c000200 2
1 000 00000000 00000000 1c000200 0 00 00000000 000 0000000f 0 1c000204 0
1 001 00000000 00000000 1c000204 0 00 00000000 000 00000007 0 1c000208 0
4 000 00000000 00000000 1c000300 1 09 1c0fff03 000 0000000f 1 1c008000 1
1 007 00000000 00000000 1c008000 0 00 00000000 000 1c0fff03 0 1c008004 0
1 005 00000000 00000000 1c008004 0 00 00000000 000 00090000 0 1c008008 0
1 123 00000000 00000000 1c008008 0 00 00000000 000 00000000 0 1c00800c 0
2 032 deadbeef ffffffff 1c00800c 0 00 00000000 000 00000000 0 00000000 3
1 032 00000000 00000000 1c008010 0 00 00000000 000 33333333 0 1c008014 0
2 004 00000800 ffffffff 1c008014 0 00 00000000 000 00001bff 1 1c008018 0
2 000 00000004 ffffffff 1c008018 0 00 00000000 000 00000008 1 1c00801c 0
2 041 00000011 ffffffff 1c00801c 0 00 00000000 000 00000000 1 1c008020 0
0 000 00000000 00000000 1c008020 0 00 00000000 000 00000000 1 1c008000 4
1 005 00000000 00000000 1c008000 0 00 00000000 000 00000800 0 1c008004 0
1 001 00000000 00000000 1c008004 0 00 00000000 000 00000004 0 1c008008 0
2 044 00000001 ffffffff 1c008008 0 00 00000000 000 00000000 1 1c00800c 0
1 005 00000000 00000000 1c00800c 0 00 00000000 000 00000000 0 1c008010 0

//--- csr_unit.f
common/csr_pkg.sv
design/csr_decode.sv
design/csr_stage_reg.sv
csr_regfile/csr_timer.sv
csr_regfile/csr_regfile.sv
design/csr_unit.sv
bench/csr_unit_sva.sv
bench/csr_unit_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the csr unit testbench with verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module csr_unit_tb -f csr_unit.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out="$(./obj_dir/Vcsr_unit_tb)"
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "sim passed"; then
    exit 0
fi
exit 1

//--- bench/csr_unit_tb.sv
`timescale 1ns/100ps

module csr_unit_tb;
    import csr_pkg::*;

    localparam string DATA_FILE     = "bench/csr_unit_testdata.txt";
    localparam int    PULSE_TIMEOUT = 8;
    localparam int    IRQ_TIMEOUT   = 200;

    logic      clk;
    logic      rstn;
    logic      stall;
    logic      flush;
    logic      req_valid;
    csr_op_e   op;
    csr_num_t  csr_num;
    word_t     wdata;
    word_t     wmask;
    word_t     pc;
    logic      excp_valid;
    ecode_t    ecode;
    esubcode_t esubcode;
    word_t     badv;
    hw_int_t   hw_int;
    word_t     rdata;
    redirect_t redirect;
    logic      excp_flush;
    logic      ertn_flush;
    plv_t      crmd_plv;
    logic      crmd_ie;

    // one data file row with all columns in hex
    logic [31:0] f_op, f_csr, f_wdata, f_wmask, f_pc, f_ev, f_ec;
    logic [31:0] f_badv, f_hw, f_rd, f_fl, f_tpc, f_mode;

    int value_errors = 0;
    int other_errors = 0;
    int line_no      = 0;

    csr_unit dut_i (
        .clk        (clk),
        .rstn       (rstn),
        .stall      (stall),
        .flush      (flush),
        .req_valid  (req_valid),
        .op         (op),
        .csr_num    (csr_num),
        .wdata      (wdata),
        .wmask      (wmask),
        .pc         (pc),
        .excp_valid (excp_valid),
        .ecode      (ecode),
        .esubcode   (esubcode),
        .badv       (badv),
        .hw_int     (hw_int),
        .rdata      (rdata),
        .redirect   (redirect),
        .excp_flush (excp_flush),
        .ertn_flush (ertn_flush),
        .crmd_plv   (crmd_plv),
        .crmd_ie    (crmd_ie)
    );

    initial
    begin
        clk = 1'b0;
    end

    always #5 clk = ~clk;

    task automatic check_word(input string what, input word_t got, input word_t exp);
        assert (got === exp)
        else
        begin
            $display("FAIL %0t: line %0d %s is %h, expected %h", $time, line_no, what, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        assert (got === exp)
        else
        begin
            $display("FAIL %0t: line %0d %s is %b, expected %b", $time, line_no, what, got, exp);
            value_errors++;
        end
    endtask

    task automatic drive_idle();
        req_valid  = 1'b0;
        op         = OP_NONE;
        excp_valid = 1'b0;
        flush      = 1'b0;
    endtask

    task automatic wait_for_pulse(input logic want_ertn);
        int   n;
        logic seen;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < PULSE_TIMEOUT)
        begin
            @(posedge clk);
            #1;
            seen = want_ertn ? ertn_flush : excp_flush;
            n++;
        end
        if (!seen)
        begin
            $display("line %0d: no %s pulse came within %0d cycles", line_no,
                     want_ertn ? "ertn_flush" : "excp_flush", PULSE_TIMEOUT);
            other_errors++;
        end
    endtask

    // interrupts arrive on their own, so poll for the redirect
    task automatic wait_for_redirect();
        int n;
        n = 0;
        while (!redirect.flush && n < IRQ_TIMEOUT)
        begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!redirect.flush)
        begin
            $display("line %0d: no interrupt redirect within %0d cycles", line_no, IRQ_TIMEOUT);
            other_errors++;
        end
    endtask

    task automatic apply_line();
        if (f_mode == 4)
        begin
            wait_for_redirect();
            check_word("redirect target", redirect.target, f_tpc);
            wait_for_pulse(1'b0);
        end
        else
        begin
            req_valid  = 1'b1;
            op         = csr_op_e'(f_op[2:0]);
            csr_num    = f_csr[13:0];
            wdata      = f_wdata;
            wmask      = f_wmask;
            pc         = f_pc;
            excp_valid = f_ev[0];
            ecode      = f_ec[5:0];
            badv       = f_badv;
            hw_int     = f_hw[8:0];
            flush      = (f_mode == 3);   // request dropped by pipeline flush
            @(posedge clk);
            #1;
            check_bit("redirect flush", redirect.flush, f_fl[0]);
            if (f_mode != 3)
            begin
                check_word("rdata", rdata, f_rd);
                check_word("redirect target", redirect.target, f_tpc);
                if (op == OP_CSRRD && csr_num == CSR_CRMD)
                begin
                    // pipeline view of crmd matches the value just read
                    check_word("crmd_ie and crmd_plv", {29'b0, crmd_ie, crmd_plv},
                               {29'b0, f_rd[2:0]});
                end
            end
            drive_idle();
            if (f_mode == 1 || f_mode == 2)
            begin
                wait_for_pulse(f_mode == 2);
            end
            else
            begin
                @(posedge clk);
                #1;
                check_bit("excp_flush", excp_flush, 1'b0);
                check_bit("ertn_flush", ertn_flush, 1'b0);
            end
        end
    endtask

    initial
    begin
        int    fd;
        int    n;
        string line;
        rstn     = 1'b0;
        stall    = 1'b0;
        csr_num  = '0;
        wdata    = '0;
        wmask    = '0;
        pc       = '0;
        ecode    = '0;
        esubcode = '0;
        badv     = '0;
        hw_int   = '0;
        drive_idle();
        repeat (4) @(posedge clk);
        #1;
        rstn = 1'b1;
        check_bit("redirect flush after reset", redirect.flush, 1'b0);
        check_bit("excp_flush after reset", excp_flush, 1'b0);
        check_bit("ertn_flush after reset", ertn_flush, 1'b0);
        check_word("crmd plv and ie after reset", {29'b0, crmd_ie, crmd_plv}, 32'h0);

        fd = $fopen(DATA_FILE, "r");
        if (fd == 0)
        begin
            $display("cannot open the data file %s", DATA_FILE);
            other_errors++;
        end
        else
        begin
            while ($fgets(line, fd) != 0)
            begin
                line_no++;
                if (line.len() < 4 || line.getc(0) == "#")
                begin
                    continue;
                end
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                            f_op, f_csr, f_wdata, f_wmask, f_pc, f_ev, f_ec,
                            f_badv, f_hw, f_rd, f_fl, f_tpc, f_mode);
                if (n != 13)
                begin
                    $display("line %0d of the data file has %0d fields instead of 13", line_no, n);
                    other_errors++;
                    continue;
                end
                apply_line();
            end
            $fclose(fd);
        end

        $display("errors: %0d wrong values, %0d other", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
        begin
            $display("sim passed");
        end
        else
        begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- bench/csr_unit_sva.sv
`timescale 1ns/100ps

module csr_unit_sva (
    input logic clk,
    input logic rstn,
    input logic excp_flush,
    input logic ertn_flush
);

    // exception and return never commit in the same cycle
    a_flush_exclusive: assert property (@(posedge clk) disable iff (!rstn)
        !(excp_flush && ertn_flush))
        else $error("excp_flush and ertn_flush high together");

    a_excp_one_cycle: assert property (@(posedge clk) disable iff (!rstn)
        excp_flush |=> !excp_flush)
        else $error("excp_flush high for more than one cycle");

    a_ertn_one_cycle: assert property (@(posedge clk) disable iff (!rstn)
        ertn_flush |=> !ertn_flush)
        else $error("ertn_flush high for more than one cycle");

    // flops are cleared by the reset edge
    a_quiet_in_reset: assert property (@(posedge clk)
        !rstn |=> !excp_flush && !ertn_flush)
        else $error("flush pulse seen during reset");

endmodule

bind csr_unit csr_unit_sva sva_i (
    .clk        (clk),
    .rstn       (rstn),
    .excp_flush (excp_flush),
    .ertn_flush (ertn_flush)
);

//--- design/csr_unit.sv
`timescale 1ns/100ps

module csr_unit (
    input  logic               clk,
    input  logic               rstn,
    input  logic               stall,
    input  logic               flush,
    input  logic               req_valid,
    input  csr_pkg::csr_op_e   op,
    input  csr_pkg::csr_num_t  csr_num,
    input  csr_pkg::word_t     wdata,
    input  csr_pkg::word_t     wmask,
    input  csr_pkg::word_t     pc,
    input  logic               excp_valid,
    input  csr_pkg::ecode_t    ecode,
    input  csr_pkg::esubcode_t esubcode,
    input  csr_pkg::word_t     badv,
    input  csr_pkg::hw_int_t   hw_int,
    output csr_pkg::word_t     rdata,
    output csr_pkg::redirect_t redirect,
    output logic               excp_flush,
    output logic               ertn_flush,
    output csr_pkg::plv_t      crmd_plv,
    output logic               crmd_ie
);
    import csr_pkg::*;

    csr_req_t req;
    csr_req_t stage_req;
    word_t    cur_rdata;
    word_t    eentry;
    word_t    era;
    word_t    tcfg_wdata;
    word_t    tval;
    logic     int_pending;
    logic     excp_busy;
    logic     commit;
    logic     tcfg_we;
    logic     ticlr;
    logic     timer_int;

    csr_decode decode_i (
        .op          (op),
        .csr_num     (csr_num),
        .wdata       (wdata),
        .wmask       (wmask),
        .pc          (pc),
        .excp_valid  (excp_valid),
        .ecode       (ecode),
        .esubcode    (esubcode),
        .badv        (badv),
        .cur_rdata   (cur_rdata),
        .int_pending (int_pending),
        .excp_busy   (excp_busy),
        .req         (req)
    );

    csr_stage_reg stage_i (
        .clk       (clk),
        .rstn      (rstn),
        .stall     (stall),
        .flush     (flush),
        .req_valid (req_valid),
        .req       (req),
        .eentry    (eentry),
        .era       (era),
        .cur_rdata (cur_rdata),
        .stage_req (stage_req),
        .commit    (commit),
        .excp_busy (excp_busy),
        .rdata     (rdata),
        .redirect  (redirect)
    );

    // read port follows the incoming csr number
    csr_regfile regfile_i (
        .clk         (clk),
        .rstn        (rstn),
        .commit      (commit),
        .stage_req   (stage_req),
        .rd_num      (csr_num),
        .hw_int      (hw_int),
        .timer_int   (timer_int),
        .tval        (tval),
        .rd_data     (cur_rdata),
        .eentry      (eentry),
        .era         (era),
        .int_pending (int_pending),
        .tcfg_we     (tcfg_we),
        .tcfg_wdata  (tcfg_wdata),
        .ticlr       (ticlr),
        .excp_flush  (excp_flush),
        .ertn_flush  (ertn_flush),
        .crmd_plv    (crmd_plv),
        .crmd_ie     (crmd_ie)
    );

    csr_timer timer_i (
        .clk        (clk),
        .rstn       (rstn),
        .tcfg_we    (tcfg_we),
        .tcfg_wdata (tcfg_wdata),
        .ticlr      (ticlr),
        .tval       (tval),
        .timer_int  (timer_int)
    );

endmodule

//--- csr_regfile/csr_regfile.sv
`timescale 1ns/100ps

module csr_regfile (
    input  logic              clk,
    input  logic              rstn,
    input  logic              commit,
    input  csr_pkg::csr_req_t stage_req,
    input  csr_pkg::csr_num_t rd_num,
    input  csr_pkg::hw_int_t  hw_int,
    input  logic              timer_int,
    input  csr_pkg::word_t    tval,
    output csr_pkg::word_t    rd_data,
    output csr_pkg::word_t    eentry,
    output csr_pkg::word_t    era,
    output logic              int_pending,
    output logic              tcfg_we,
    output csr_pkg::word_t    tcfg_wdata,
    output logic              ticlr,
    output logic              excp_flush,
    output logic              ertn_flush,
    output csr_pkg::plv_t     crmd_plv,
    output logic              crmd_ie
);
    import csr_pkg::*;

    word_t       crmd_q;
    logic [2:0]  prmd_q;          // {pie, pplv}
    logic [12:0] ecfg_lie;
    logic [1:0]  estat_sw;
    ecode_t      estat_ecode;
    esubcode_t   estat_esubcode;
    word_t       era_q;
    word_t       badv_q;
    logic [31:6] eentry_q;
    word_t       save_q [4];
    word_t       tid_q;
    word_t       tcfg_q;
    logic [12:0] is_vec;
    logic        csr_we;
    logic        excp_go;
    logic        ertn_go;

    assign csr_we  = commit && (stage_req.op == OP_CSRWR || stage_req.op == OP_CSRXCHG);
    assign excp_go = commit && (stage_req.op == OP_EXCP);
    assign ertn_go = commit && (stage_req.op == OP_ERTN);

    // ipi, timer, reserved, hw[7:0], sw[1:0]
    assign is_vec      = {hw_int[8], timer_int, 1'b0, hw_int[7:0], estat_sw};
    assign int_pending = crmd_q[2] && |(is_vec & ecfg_lie);

    assign ticlr = csr_we && (stage_req.csr_num == CSR_TICLR) && stage_req.wdata[0];

    assign crmd_plv   = crmd_q[1:0];
    assign crmd_ie    = crmd_q[2];
    assign era        = era_q;
    assign eentry     = {eentry_q, 6'b0};
    assign tcfg_wdata = tcfg_q;

    always_comb
    begin
        case (rd_num)
            CSR_CRMD:   rd_data = crmd_q;
            CSR_PRMD:   rd_data = {29'b0, prmd_q};
            CSR_ECFG:   rd_data = {19'b0, ecfg_lie};
            CSR_ESTAT:  rd_data = {1'b0, estat_esubcode, estat_ecode, 3'b0, is_vec};
            CSR_ERA:    rd_data = era_q;
            CSR_BADV:   rd_data = badv_q;
            CSR_EENTRY: rd_data = {eentry_q, 6'b0};
            CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3:
                rd_data = save_q[rd_num[1:0]];
            CSR_TID:    rd_data = tid_q;
            CSR_TCFG:   rd_data = tcfg_q;
            CSR_TVAL:   rd_data = tval;
            default:    rd_data = '0;  // ticlr and unknown numbers
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            crmd_q         <= CRMD_RESET;
            prmd_q         <= '0;
            ecfg_lie       <= '0;
            estat_sw       <= '0;
            estat_ecode    <= '0;
            estat_esubcode <= '0;
            era_q          <= '0;
            badv_q         <= '0;
            eentry_q       <= '0;
            for (int i = 0; i < 4; i++)
            begin
                save_q[i] <= '0;
            end
            tid_q          <= '0;
            tcfg_q         <= '0;
            tcfg_we        <= 1'b0;
            excp_flush     <= 1'b0;
            ertn_flush     <= 1'b0;
        end
        else
        begin
            excp_flush <= excp_go;
            ertn_flush <= ertn_go;
            tcfg_we    <= csr_we && (stage_req.csr_num == CSR_TCFG);  // timer reloads next
            if (excp_go)
            begin
                prmd_q         <= crmd_q[2:0];
                crmd_q[2:0]    <= 3'b000;
                era_q          <= stage_req.pc;
                estat_ecode    <= stage_req.ecode;
                estat_esubcode <= stage_req.esubcode;
                if (stage_req.ecode == EC_ALE || stage_req.ecode == EC_ADE)
                begin
                    badv_q <= stage_req.badv;
                end
            end
            else if (ertn_go)
            begin
                crmd_q[2:0] <= prmd_q;
            end
            else if (csr_we)
            begin
                case (stage_req.csr_num)
                    CSR_CRMD:   crmd_q[2:0] <= stage_req.wdata[2:0];
                    CSR_PRMD:   prmd_q <= stage_req.wdata[2:0];
                    CSR_ECFG:   ecfg_lie <= stage_req.wdata[12:0] & ECFG_LIE_MASK[12:0];
                    CSR_ESTAT:  estat_sw <= stage_req.wdata[1:0];  // only sw bits writable
                    CSR_ERA:    era_q <= stage_req.wdata;
                    CSR_BADV:   badv_q <= stage_req.wdata;
                    CSR_EENTRY: eentry_q <= stage_req.wdata[31:6];
                    CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3:
                        save_q[stage_req.csr_num[1:0]] <= stage_req.wdata;
                    CSR_TID:    tid_q <= stage_req.wdata;
                    CSR_TCFG:   tcfg_q <= stage_req.wdata;
                    default:    ;
                endcase
            end
        end
    end

endmodule

//--- csr_regfile/csr_timer.sv
`timescale 1ns/100ps

module csr_timer (
    input  logic           clk,
    input  logic           rstn,
    input  logic           tcfg_we,
    input  csr_pkg::word_t tcfg_wdata,
    input  logic           ticlr,
    output csr_pkg::word_t tval,
    output logic           timer_int
);
    import csr_pkg::*;

    word_t init_val;
    logic  en;
    logic  periodic;
    logic  at_zero;

    assign en       = tcfg_wdata[0];
    assign periodic = tcfg_wdata[1];
    assign init_val = {tcfg_wdata[31:2], 2'b00};
    assign at_zero  = (tval == '0);

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            tval      <= '0;
            timer_int <= 1'b0;
        end
        else
        begin
            if (ticlr)
            begin
                timer_int <= 1'b0;  // clear wins over a new set
            end
            else if (en && at_zero && !tcfg_we)
            begin
                timer_int <= 1'b1;
            end

            if (tcfg_we)
            begin
                tval <= init_val;
            end
            else if (en)
            begin
                if (at_zero && periodic)
                begin
                    tval <= init_val;
                end
                else if (tval != '1)
                begin
                    tval <= tval - 32'd1;  // one-shot parks at all ones
                end
            end
        end
    end

endmodule

//--- design/csr_stage_reg.sv
`timescale 1ns/100ps

module csr_stage_reg (
    input  logic               clk,
    input  logic               rstn,
    input  logic               stall,
    input  logic               flush,
    input  logic               req_valid,
    input  csr_pkg::csr_req_t  req,
    input  csr_pkg::word_t     eentry,
    input  csr_pkg::word_t     era,
    input  csr_pkg::word_t     cur_rdata,
    output csr_pkg::csr_req_t  stage_req,
    output logic               commit,
    output logic               excp_busy,
    output csr_pkg::word_t     rdata,
    output csr_pkg::redirect_t redirect
);
    import csr_pkg::*;

    csr_op_e  op_q;
    csr_req_t req_q;
    word_t    rdata_q;
    logic     flush_q;
    word_t    target_q;
    word_t    target;
    logic     take;

    // exceptions and interrupts enter even under stall or flush
    assign take = (req.op == OP_EXCP) || (req_valid && !stall && !flush);

    always_comb
    begin
        case (req.op)
            OP_EXCP: target = eentry;
            OP_ERTN: target = era;
            default: target = req.pc + 32'd4;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            op_q    <= OP_NONE;
            flush_q <= 1'b0;
            commit  <= 1'b0;
        end
        else
        begin
            commit <= take;  // single strobe, never repeated under stall
            if (take)
            begin
                op_q    <= req.op;
                flush_q <= (req.op != OP_NONE) && (req.op != OP_CSRRD);
            end
            else if (flush || !stall)
            begin
                op_q    <= OP_NONE;
                flush_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (take)
        begin
            req_q    <= req;
            rdata_q  <= cur_rdata;  // old value of the addressed csr
            target_q <= target;
        end
    end

    always_comb
    begin
        stage_req       = req_q;
        stage_req.op    = op_q;
        redirect.flush  = flush_q;
        redirect.target = target_q;
    end

    assign rdata     = rdata_q;
    assign excp_busy = (op_q == OP_EXCP);

endmodule

//--- design/csr_decode.sv
`timescale 1ns/100ps

module csr_decode (
    input  csr_pkg::csr_op_e   op,
    input  csr_pkg::csr_num_t  csr_num,
    input  csr_pkg::word_t     wdata,
    input  csr_pkg::word_t     wmask,
    input  csr_pkg::word_t     pc,
    input  logic               excp_valid,
    input  csr_pkg::ecode_t    ecode,
    input  csr_pkg::esubcode_t esubcode,
    input  csr_pkg::word_t     badv,
    input  csr_pkg::word_t     cur_rdata,
    input  logic               int_pending,
    input  logic               excp_busy,
    output csr_pkg::csr_req_t  req
);
    import csr_pkg::*;

    word_t merged;
    logic  take_int;
    logic  addr_fault;

    // bits outside the mask keep the current csr value
    assign merged = (cur_rdata & ~wmask) | (wdata & wmask);

    // no second interrupt while the stage still holds an exception
    assign take_int = int_pending && !excp_busy;

    assign addr_fault = (ecode == EC_ALE) || (ecode == EC_ADE);

    always_comb
    begin
        req          = '0;
        req.op       = op;
        req.csr_num  = csr_num;
        req.pc       = pc;
        req.wdata    = wdata;     // csrwr writes the full word

        if (op == OP_CSRXCHG)
        begin
            req.wdata = merged;
        end

        if (take_int)
        begin
            req.op       = OP_EXCP;
            req.ecode    = EC_INT;
            req.esubcode = '0;
            req.badv     = '0;
        end
        else if (excp_valid)
        begin
            req.op       = OP_EXCP;
            req.ecode    = ecode;
            req.esubcode = esubcode;
            if (addr_fault)
            begin
                req.badv = badv;  // only address faults capture badv
            end
        end
    end

endmodule

//--- common/csr_pkg.sv
package csr_pkg;

    typedef logic [31:0] word_t;
    typedef logic [13:0] csr_num_t;
    typedef logic [5:0]  ecode_t;
    typedef logic [8:0]  esubcode_t;
    typedef logic [1:0]  plv_t;
    typedef logic [8:0]  hw_int_t;     // [8] is the inter-core line

    typedef enum logic [2:0] {
        OP_NONE    = 3'd0,
        OP_CSRRD   = 3'd1,
        OP_CSRWR   = 3'd2,
        OP_CSRXCHG = 3'd3,
        OP_EXCP    = 3'd4,
        OP_ERTN    = 3'd5
    } csr_op_e;

    // one privileged request as it leaves decode
    typedef struct packed {
        csr_op_e   op;
        csr_num_t  csr_num;
        word_t     wdata;      // xchg mask already applied
        word_t     pc;
        ecode_t    ecode;
        esubcode_t esubcode;
        word_t     badv;
    } csr_req_t;

    typedef struct packed {
        logic  flush;
        word_t target;
    } redirect_t;

    // csr numbers
    localparam csr_num_t CSR_CRMD   = 14'h00;
    localparam csr_num_t CSR_PRMD   = 14'h01;
    localparam csr_num_t CSR_ECFG   = 14'h04;
    localparam csr_num_t CSR_ESTAT  = 14'h05;
    localparam csr_num_t CSR_ERA    = 14'h06;
    localparam csr_num_t CSR_BADV   = 14'h07;
    localparam csr_num_t CSR_EENTRY = 14'h0c;
    localparam csr_num_t CSR_SAVE0  = 14'h30;
    localparam csr_num_t CSR_SAVE1  = 14'h31;
    localparam csr_num_t CSR_SAVE2  = 14'h32;
    localparam csr_num_t CSR_SAVE3  = 14'h33;
    localparam csr_num_t CSR_TID    = 14'h40;
    localparam csr_num_t CSR_TCFG   = 14'h41;
    localparam csr_num_t CSR_TVAL   = 14'h42;
    localparam csr_num_t CSR_TICLR  = 14'h44;

    // exception codes
    localparam ecode_t EC_INT = 6'h00;
    localparam ecode_t EC_ADE = 6'h08;
    localparam ecode_t EC_ALE = 6'h09;
    localparam ecode_t EC_SYS = 6'h0b;
    localparam ecode_t EC_BRK = 6'h0c;
    localparam ecode_t EC_INE = 6'h0d;

    // lie bits 12:11 and 9:0 with bit 10 reserved
    localparam word_t ECFG_LIE_MASK = 32'h0000_1bff;

    // da set, plv 0, ie off
    localparam word_t CRMD_RESET = 32'h0000_0008;

endpackage
